//--- rv_pkg.sv
package rv_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  // Base opcodes, RV32I
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_FENCE  = 7'b0001111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [3:0] ALU_ADD    = 4'd0;
  localparam logic [3:0] ALU_SUB    = 4'd1;
  localparam logic [3:0] ALU_SLL    = 4'd2;
  localparam logic [3:0] ALU_SLT    = 4'd3;
  localparam logic [3:0] ALU_SLTU   = 4'd4;
  localparam logic [3:0] ALU_XOR    = 4'd5;
  localparam logic [3:0] ALU_SRL    = 4'd6;
  localparam logic [3:0] ALU_SRA    = 4'd7;
  localparam logic [3:0] ALU_OR     = 4'd8;
  localparam logic [3:0] ALU_AND    = 4'd9;
  localparam logic [3:0] ALU_PASS_B = 4'd10; // LUI

  // Writeback source
  localparam logic [1:0] WB_ALU  = 2'd0;
  localparam logic [1:0] WB_LOAD = 2'd1;
  localparam logic [1:0] WB_PC4  = 2'd2;

  // One instruction word, six format views
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } insn_t;

endpackage

//--- rv_reg_file.sv
`timescale 1ns/1ns

module rv_reg_file import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            we,
  input  logic [4:0]      rd,
  input  logic [XLEN-1:0] rd_data,
  input  logic [4:0]      rs1,
  output logic [XLEN-1:0] rs1_data,
  input  logic [4:0]      rs2,
  output logic [XLEN-1:0] rs2_data
);

  logic [XLEN-1:0] regs [1:NUM_REGS-1]; // No storage for x0

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 1; k < NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder import rv_pkg::*; (
  input  insn_t           insn,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output logic [4:0]      rd,
  output logic [XLEN-1:0] imm,
  output logic [3:0]      alu_op,
  output logic            alu_src_imm,
  output logic            alu_src_pc,
  output logic            rd_we,
  output logic [1:0]      wb_sel,
  output logic            branch,
  output logic            jump,
  output logic            jump_reg,
  output logic            mem_read,
  output logic            mem_write,
  output logic [2:0]      funct3,
  output logic            halt
);

  logic [3:0] arith_op; // Shared OP and OP-IMM mapping

  // Register fields sit in the same place in every format
  assign rs1    = insn.r.rs1;
  assign rs2    = insn.r.rs2;
  assign rd     = insn.r.rd;
  assign funct3 = insn.r.funct3;

  always_comb begin
    case (insn.r.funct3)
      3'b000: arith_op = (insn.r.opcode == OP_REG && insn.r.funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001: arith_op = ALU_SLL;
      3'b010: arith_op = ALU_SLT;
      3'b011: arith_op = ALU_SLTU;
      3'b100: arith_op = ALU_XOR;
      3'b101: arith_op = insn.r.funct7[5] ? ALU_SRA : ALU_SRL; // SRAI too
      3'b110: arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    imm         = {{20{insn.i.imm[11]}}, insn.i.imm};
    alu_op      = ALU_ADD;
    alu_src_imm = 1'b0;
    alu_src_pc  = 1'b0;
    rd_we       = 1'b0;
    wb_sel      = WB_ALU;
    branch      = 1'b0;
    jump        = 1'b0;
    jump_reg    = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    halt        = 1'b0;
    case (insn.r.opcode)
      OP_LUI: begin
        imm         = {insn.u.imm, 12'h000};
        alu_op      = ALU_PASS_B;
        alu_src_imm = 1'b1;
        rd_we       = 1'b1;
      end
      OP_AUIPC: begin
        imm         = {insn.u.imm, 12'h000};
        alu_src_imm = 1'b1;
        alu_src_pc  = 1'b1;
        rd_we       = 1'b1;
      end
      OP_JAL: begin
        imm    = {{11{insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
                  insn.j.imm_11, insn.j.imm_10_1, 1'b0};
        rd_we  = 1'b1;
        wb_sel = WB_PC4;
        jump   = 1'b1;
      end
      OP_JALR: begin
        alu_src_imm = 1'b1; // Target is rs1 + imm
        rd_we       = 1'b1;
        wb_sel      = WB_PC4;
        jump_reg    = 1'b1;
      end
      OP_BRANCH: begin
        imm    = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                  insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
        branch = 1'b1;
      end
      OP_LOAD: begin
        alu_src_imm = 1'b1;
        rd_we       = 1'b1;
        wb_sel      = WB_LOAD;
        mem_read    = 1'b1;
      end
      OP_STORE: begin
        imm         = {{20{insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
      end
      OP_IMM: begin
        alu_op      = arith_op;
        alu_src_imm = 1'b1;
        rd_we       = 1'b1;
      end
      OP_REG: begin
        alu_op = arith_op;
        rd_we  = 1'b1;
      end
      OP_FENCE: ; // Nothing to order in a single-cycle core
      OP_SYSTEM: halt = (insn.i.imm == 12'h000) && (insn.i.funct3 == 3'b000); // ECALL
      default: ; // Unknown, retire as no-op
    endcase
  end

endmodule

//--- rv_alu.sv
`timescale 1ns/1ns

module rv_alu import rv_pkg::*; (
  input  logic [3:0]      op,
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  logic [2:0]      br_funct3,
  output logic [XLEN-1:0] result,
  output logic            br_taken
);

  localparam int SHW = $clog2(XLEN);

  logic            lt_s;
  logic            lt_u;
  logic            eq;
  logic [SHW-1:0]  shamt;

  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;
  assign eq    = a == b;
  assign shamt = b[SHW-1:0]; // Only low bits count

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:   result = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // Branch condition
  always_comb begin
    case (br_funct3)
      3'b000:  br_taken = eq;    // BEQ
      3'b001:  br_taken = !eq;   // BNE
      3'b100:  br_taken = lt_s;  // BLT
      3'b101:  br_taken = !lt_s; // BGE
      3'b110:  br_taken = lt_u;  // BLTU
      3'b111:  br_taken = !lt_u; // BGEU
      default: br_taken = 1'b0;
    endcase
  end

endmodule

//--- rv_lsu.sv
`timescale 1ns/1ns

module rv_lsu import rv_pkg::*; (
  input  logic [XLEN-1:0] addr,
  input  logic [XLEN-1:0] store_data,
  input  logic [2:0]      funct3,
  input  logic            mem_write,
  input  logic [XLEN-1:0] dmem_rdata,
  output logic [XLEN-1:0] dmem_addr,
  output logic [XLEN-1:0] dmem_wdata,
  output logic [3:0]      dmem_wstrb,
  output logic [XLEN-1:0] load_data
);

  logic [1:0]      offset;
  logic [XLEN-1:0] lane; // Addressed bytes moved to bit 0

  assign offset    = addr[1:0];
  assign dmem_addr = {addr[XLEN-1:2], 2'b00};
  assign lane      = dmem_rdata >> {offset, 3'b000};

  // Store data goes into every lane, the strobe picks the right one
  always_comb begin
    case (funct3[1:0])
      2'b00: begin // SB
        dmem_wdata = {4{store_data[7:0]}};
        dmem_wstrb = 4'b0001 << offset;
      end
      2'b01: begin // SH
        dmem_wdata = {2{store_data[15:0]}};
        dmem_wstrb = 4'b0011 << {offset[1], 1'b0};
      end
      default: begin
        dmem_wdata = store_data;
        dmem_wstrb = 4'b1111;
      end
    endcase
    if (!mem_write) begin
      dmem_wstrb = 4'b0000;
    end
  end

  always_comb begin
    case (funct3)
      3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};   // LB
      3'b001:  load_data = {{16{lane[15]}}, lane[15:0]}; // LH
      3'b100:  load_data = {24'h000000, lane[7:0]};      // LBU
      3'b101:  load_data = {16'h0000, lane[15:0]};       // LHU
      default: load_data = dmem_rdata;                   // LW
    endcase
  end

endmodule

//--- rv_core.sv
`timescale 1ns/1ns

module rv_core import rv_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst,
  output logic [XLEN-1:0] imem_addr,
  input  logic [XLEN-1:0] imem_rdata,
  output logic [XLEN-1:0] dmem_addr,
  output logic [XLEN-1:0] dmem_wdata,
  output logic [3:0]      dmem_wstrb,
  input  logic [XLEN-1:0] dmem_rdata,
  output logic            halt,
  output logic            wb_valid,
  output logic            wb_we,
  output logic [4:0]      wb_rd,
  output logic [XLEN-1:0] wb_data,
  output logic [XLEN-1:0] wb_pc
);

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_next;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] pc_target;

  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  logic [XLEN-1:0] imm;
  logic [3:0]      alu_op;
  logic            alu_src_imm;
  logic            alu_src_pc;
  logic            rd_we;
  logic [1:0]      wb_sel;
  logic            branch;
  logic            jump;
  logic            jump_reg;
  logic            mem_read;
  logic            mem_write;
  logic [2:0]      funct3;

  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_result;
  logic            br_taken;
  logic [XLEN-1:0] mem_addr;
  logic [XLEN-1:0] load_data;
  logic [XLEN-1:0] wb_value;
  logic            retire;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign imem_addr = pc;
  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm; // Branch and JAL

  always_comb begin
    if (halt)                        pc_next = pc; // ECALL freezes the core
    else if (jump_reg)               pc_next = {alu_result[XLEN-1:1], 1'b0};
    else if (jump || (branch && br_taken)) pc_next = pc_target;
    else                             pc_next = pc_plus4;
  end

  rv_decoder decoder_inst (
    .insn(imem_rdata), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
    .alu_src_imm(alu_src_imm), .alu_src_pc(alu_src_pc), .rd_we(rd_we), .wb_sel(wb_sel),
    .branch(branch), .jump(jump), .jump_reg(jump_reg), .mem_read(mem_read),
    .mem_write(mem_write), .funct3(funct3), .halt(halt)
  );

  rv_reg_file reg_file_inst (
    .clk(clk), .rst(rst), .we(wb_we), .rd(rd), .rd_data(wb_value),
    .rs1(rs1), .rs1_data(rs1_data), .rs2(rs2), .rs2_data(rs2_data)
  );

  assign alu_a = alu_src_pc ? pc : rs1_data;
  assign alu_b = alu_src_imm ? imm : rs2_data;

  rv_alu alu_inst (
    .op(alu_op), .a(alu_a), .b(alu_b), .br_funct3(funct3),
    .result(alu_result), .br_taken(br_taken)
  );

  // Data address stays quiet unless memory is touched
  assign mem_addr = (mem_read || mem_write) ? alu_result : '0;

  rv_lsu lsu_inst (
    .addr(mem_addr), .store_data(rs2_data), .funct3(funct3),
    .mem_write(mem_write && retire), .dmem_rdata(dmem_rdata), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_wstrb(dmem_wstrb), .load_data(load_data)
  );

  always_comb begin
    case (wb_sel)
      WB_LOAD: wb_value = load_data;
      WB_PC4:  wb_value = pc_plus4;
      default: wb_value = alu_result;
    endcase
  end

  assign retire   = !rst && !halt;
  assign wb_valid = retire;
  assign wb_we    = retire && rd_we && (rd != 5'd0);
  assign wb_rd    = rd;
  assign wb_data  = wb_value;
  assign wb_pc    = pc;

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;

  localparam logic [31:0] RESET_PC   = 32'h0000_0000;
  localparam logic [31:0] SEED       = 32'he96f8f4d;
  localparam int          MAX_CYCLES = 200; // 4 reset + 49 retired + 11 halted, plus margin
  localparam int          HALT_WAIT  = 10;

  // RV32I major opcodes used by the encoders
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;

  // One expected retirement
  typedef struct packed {
    logic [2:0]  test;
    logic [31:0] pc;
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] daddr;
    logic [31:0] wdata;
  } retire_t;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wstrb;
  logic [31:0] dmem_rdata;
  logic        halt;
  logic        wb_valid;
  logic        wb_we;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic [31:0] wb_pc;

  logic [31:0] imem [0:63];
  logic [31:0] dmem [0:63];
  logic [31:0] rf [0:31];   // Register state as the program is built
  logic [31:0] dm [0:63];   // Data memory state as the program is built
  retire_t     exp_q [$];
  logic [31:0] pc_b;
  logic [31:0] halt_pc_exp;
  logic [31:0] ra;
  logic [31:0] rb;
  logic [31:0] u_imm;
  logic        started = 1'b0;
  logic        halted = 1'b0;
  logic        done = 1'b0;
  int          halt_cycles = 0;
  int          cycles = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  int          checks [1:6];
  int          errs [1:6];
  string       names [1:6];

  always #4 clk = ~clk;

  rv_core #(.RESET_PC(RESET_PC)) rv_core_inst (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_wstrb(dmem_wstrb),
    .dmem_rdata(dmem_rdata), .halt(halt), .wb_valid(wb_valid), .wb_we(wb_we),
    .wb_rd(wb_rd), .wb_data(wb_data), .wb_pc(wb_pc)
  );

  assign imem_rdata = imem[imem_addr[7:2]];
  assign dmem_rdata = dmem[dmem_addr[7:2]]; // Old word until the edge

  always @(posedge clk) begin
    for (int k = 0; k < 4; k++) begin
      if (dmem_wstrb[k]) begin
        dmem[dmem_addr[7:2]][8*k +: 8] <= dmem_wdata[8*k +: 8];
      end
    end
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Load result from the modelled data memory
  function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] addr);
    logic [31:0] word;
    word = dm[addr[7:2]] >> (8 * addr[1:0]);
    case (f3)
      3'b000:  return {{24{word[7]}}, word[7:0]};
      3'b001:  return {{16{word[15]}}, word[15:0]};
      3'b100:  return {24'h0, word[7:0]};
      3'b101:  return {16'h0, word[15:0]};
      default: return word;
    endcase
  endfunction

  task automatic put(input logic [31:0] insn);
    imem[pc_b[7:2]] = insn;
    pc_b = pc_b + 32'd4;
  endtask

  task automatic put_poison();
    put(enc_i(12'h7ff, 5'd0, 3'b000, 5'd31, OPC_IMM)); // Must never retire
  endtask

  task automatic emit(input int t, input logic [31:0] insn, input logic [4:0] rd,
                      input logic [31:0] value);
    retire_t e;
    e = '0;
    e.test = t;
    e.pc = pc_b;
    e.we = (rd != 5'd0);
    e.rd = rd;
    e.data = value;
    exp_q.push_back(e);
    if (rd != 5'd0) begin
      rf[rd] = value;
    end
    put(insn);
  endtask

  task automatic emit_store(input int t, input logic [31:0] insn, input logic [31:0] addr,
                            input logic [3:0] strb, input logic [31:0] wdata);
    retire_t e;
    e = '0;
    e.test = t;
    e.pc = pc_b;
    e.strb = strb;
    e.daddr = {addr[31:2], 2'b00};
    e.wdata = wdata;
    exp_q.push_back(e);
    for (int k = 0; k < 4; k++) begin
      if (strb[k]) begin
        dm[addr[7:2]][8*k +: 8] = wdata[8*k +: 8];
      end
    end
    put(insn);
  endtask

  task automatic emit_branch(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2);
    logic taken;
    taken = branch_taken(f3, rf[rs1], rf[rs2]);
    emit(3, enc_b(13'd8, rs2, rs1, f3), 5'd0, 32'h0);
    if (taken) begin
      put_poison(); // Jumped over
    end
  endtask

  // LUI then ADDI, the upper part rounded for the sign of the low 12 bits
  task automatic load_const(input int t, input logic [4:0] rd, input logic [31:0] value);
    logic [19:0] hi;
    hi = (value + 32'h800) >> 12;
    emit(t, enc_u(hi, rd, OPC_LUI), rd, {hi, 12'h000});
    emit(t, enc_i(value[11:0], rd, 3'b000, rd, OPC_IMM), rd, value);
  endtask

  task automatic build_program();
    logic [31:0] target;
    for (int i = 0; i < 64; i++) begin
      imem[i] = 32'h0000_0000;
      dmem[i] = 32'h9e37_79b9 * (i + 1);
      dm[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) begin
      rf[i] = 32'h0;
    end
    pc_b = RESET_PC;

    // A store sits at RESET_PC so its strobe is presented throughout reset
    emit_store(1, enc_s(12'd0, 5'd0, 5'd0, 3'b010), 32'h0, 4'b1111, 32'h0);

    load_const(2, 5'd1, $urandom());
    load_const(2, 5'd2, $urandom() | 32'h0000_8080); // Sign bits set in the stored lanes
    ra = rf[1];
    rb = rf[2];
    emit(2, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, ra + rb);
    emit(2, enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, ra - rb);
    emit(2, enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd5), 5'd5, ra ^ rb);
    emit(2, enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), 5'd6, ra | rb);
    emit(2, enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd7), 5'd7, ra & rb);
    emit(2, enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd8), 5'd8, ra << rb[4:0]);
    emit(2, enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd9), 5'd9, ra >> rb[4:0]);
    emit(2, enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd10), 5'd10, $signed(ra) >>> rb[4:0]);
    emit(2, enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd11), 5'd11,
         ($signed(ra) < $signed(rb)) ? 1 : 0);
    emit(2, enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd12), 5'd12, (ra < rb) ? 1 : 0);
    emit(2, enc_i(12'hfff, 5'd1, 3'b010, 5'd13, OPC_IMM), 5'd13, ($signed(ra) < -1) ? 1 : 0);
    emit(2, enc_i(12'hfff, 5'd1, 3'b011, 5'd14, OPC_IMM), 5'd14,
         (ra < 32'hffff_ffff) ? 1 : 0); // Immediate sign-extends before the unsigned compare
    emit(2, enc_i(12'h007, 5'd1, 3'b001, 5'd15, OPC_IMM), 5'd15, ra << 7);
    emit(2, enc_i(12'h40d, 5'd1, 3'b101, 5'd16, OPC_IMM), 5'd16, $signed(ra) >>> 13); // SRAI
    emit(2, enc_i(12'h005, 5'd1, 3'b000, 5'd0, OPC_IMM), 5'd0, 32'h0);
    emit(2, enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd19), 5'd19, 32'h0);

    emit(3, enc_i(12'hfff, 5'd0, 3'b000, 5'd22, OPC_IMM), 5'd22, 32'hffff_ffff);
    emit(3, enc_i(12'h001, 5'd0, 3'b000, 5'd23, OPC_IMM), 5'd23, 32'h1);
    emit_branch(3'b000, 5'd23, 5'd23); // BEQ
    emit_branch(3'b000, 5'd22, 5'd23);
    emit_branch(3'b001, 5'd22, 5'd23); // BNE
    emit_branch(3'b001, 5'd23, 5'd23);
    emit_branch(3'b100, 5'd22, 5'd23); // BLT
    emit_branch(3'b100, 5'd23, 5'd22);
    emit_branch(3'b101, 5'd23, 5'd22); // BGE
    emit_branch(3'b101, 5'd22, 5'd23);
    emit_branch(3'b110, 5'd23, 5'd22); // BLTU
    emit_branch(3'b110, 5'd22, 5'd23);
    emit_branch(3'b111, 5'd22, 5'd23); // BGEU
    emit_branch(3'b111, 5'd23, 5'd22);
    emit(3, enc_j(21'd8, 5'd24), 5'd24, pc_b + 32'd4);
    put_poison();
    target = (rf[24] + 32'd13) & ~32'd1; // Odd offset, bit 0 dropped
    emit(3, enc_i(12'd13, 5'd24, 3'b000, 5'd25, OPC_JALR), 5'd25, pc_b + 32'd4);
    while (pc_b != target) begin
      put_poison();
    end

    emit(4, enc_i(12'h040, 5'd0, 3'b000, 5'd26, OPC_IMM), 5'd26, 32'h40);
    emit_store(4, enc_s(12'd0, 5'd1, 5'd26, 3'b010), 32'h40, 4'b1111, ra);
    emit_store(4, enc_s(12'd5, 5'd2, 5'd26, 3'b000), 32'h45, 4'b0010, {4{rb[7:0]}});
    emit_store(4, enc_s(12'd10, 5'd2, 5'd26, 3'b001), 32'h4a, 4'b1100, {2{rb[15:0]}});
    emit(4, enc_i(12'd0, 5'd26, 3'b010, 5'd27, OPC_LOAD), 5'd27, load_value(3'b010, 32'h40));
    emit(4, enc_i(12'd5, 5'd26, 3'b000, 5'd28, OPC_LOAD), 5'd28, load_value(3'b000, 32'h45));
    emit(4, enc_i(12'd5, 5'd26, 3'b100, 5'd29, OPC_LOAD), 5'd29, load_value(3'b100, 32'h45));
    emit(4, enc_i(12'd10, 5'd26, 3'b001, 5'd30, OPC_LOAD), 5'd30, load_value(3'b001, 32'h4a));
    emit(4, enc_i(12'd10, 5'd26, 3'b101, 5'd31, OPC_LOAD), 5'd31, load_value(3'b101, 32'h4a));
    emit(4, enc_i(12'd8, 5'd26, 3'b001, 5'd28, OPC_LOAD), 5'd28, load_value(3'b001, 32'h48));

    u_imm = $urandom();
    emit(5, enc_u(u_imm[31:12], 5'd20, OPC_AUIPC), 5'd20, pc_b + {u_imm[31:12], 12'h000});
    emit(5, enc_u(u_imm[19:0], 5'd21, OPC_LUI), 5'd21, {u_imm[19:0], 12'h000});

    halt_pc_exp = pc_b;
    put(32'h0000_0073); // ECALL
  endtask

  task automatic check_value(input int t, input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks[t]++;
    assert (got === exp) pass_count++;
    else begin
      errs[t]++;
      fail_count++;
      $display("FAILED %0t: test %0d %s is %h, expected %h", $time, t, what, got, exp);
    end
  endtask

  task automatic report_error(input int t, input string msg);
    errs[t]++;
    fail_count++;
    $display("test %0d: %s (time %0t)", t, msg, $time);
  endtask

  task automatic test_done(input int t);
    $display("test %0d %s: %0d checks, %0d errors", t, names[t], checks[t], errs[t]);
  endtask

  task automatic check_retire();
    retire_t e;
    retire_t next_e;
    if (exp_q.size() == 0) begin
      report_error(6, "an instruction retired where the ECALL should have halted the core");
    end else begin
      e = exp_q.pop_front();
      check_value(e.test, "imem_addr", imem_addr, e.pc);
      check_value(e.test, "wb_pc", wb_pc, e.pc);
      check_value(e.test, "wb_we", wb_we, e.we);
      if (e.we) begin
        check_value(e.test, "wb_rd", wb_rd, e.rd);
        check_value(e.test, "wb_data", wb_data, e.data);
      end
      check_value(e.test, "dmem_wstrb", dmem_wstrb, e.strb);
      if (e.strb != 4'b0000) begin
        check_value(e.test, "dmem_addr", dmem_addr, e.daddr);
        check_value(e.test, "dmem_wdata", dmem_wdata, e.wdata);
      end
      if (exp_q.size() == 0) begin
        test_done(e.test);
      end else begin
        next_e = exp_q[0];
        if (next_e.test != e.test) begin
          test_done(e.test);
        end
      end
    end
  endtask

  task automatic check_halted();
    if (!halted) begin
      halted = 1'b1;
      if (exp_q.size() != 0) begin
        report_error(6, $sformatf("core halted with %0d instructions left", exp_q.size()));
      end
    end else begin
      halt_cycles++;
    end
    check_value(6, "halt", halt, 32'd1);
    check_value(6, "wb_valid while halted", wb_valid, 32'd0);
    check_value(6, "wb_pc while halted", wb_pc, halt_pc_exp);
    check_value(6, "dmem_wstrb while halted", dmem_wstrb, 32'd0);
    if (halt_cycles == HALT_WAIT) begin
      test_done(6);
      done = 1'b1;
    end
  endtask

  // Outputs quiet through reset
  assert property (@(posedge clk) rst |-> (!wb_valid && !wb_we && dmem_wstrb == 4'b0000))
  else begin
    errs[1]++;
    fail_count++;
    $display("FAILED %0t: test 1 core active while rst is high", $time);
  end

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (rst) begin
      check_value(1, "wb_valid during reset", wb_valid, 32'd0);
      check_value(1, "wb_we during reset", wb_we, 32'd0);
      check_value(1, "dmem_wstrb during reset", dmem_wstrb, 32'd0);
    end else if (!done) begin
      if (!started) begin
        started = 1'b1;
        check_value(1, "first wb_pc", wb_pc, RESET_PC);
      end
      if (halted || (!wb_valid && halt)) begin
        check_halted();
      end else if (wb_valid) begin
        check_retire();
      end else begin
        report_error(6, "core neither retired nor halted");
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the program never halted within %0d cycles", MAX_CYCLES);
      $display("checks passed %0d, failed %0d", pass_count, fail_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    names[1] = "reset";
    names[2] = "alu";
    names[3] = "branch and jump";
    names[4] = "load and store";
    names[5] = "upper immediate";
    names[6] = "ecall halt";
    for (int t = 1; t <= 6; t++) begin
      checks[t] = 0;
      errs[t] = 0;
    end
    void'($urandom(SEED));
    build_program();
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    wait (done);
    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- rv_core.f
rv_pkg.sv
rv_reg_file.sv
rv_decoder.sv
rv_alu.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv
